/* test/sound_registers_tests.txt */
# test <name> | w <addr> <data> | f <addr> (random data) | i <idle cycles>
# c <output> <expected hex>; outputs ch1 ch2 ch3 trig (ch1 ch2 ch3) wave control
test reset_values
c ch1 0
c ch2 0
c ch3 0
c trig 0
c control 0
c wave 0123456789abcdeffedcba9876543210
test ch1_fields
w ff10 7a
w ff11 bf
w ff12 f3
w ff13 c1
w ff14 05
c ch1 05c1f3bf7a
c trig 0
test ch2_fields
f ff15
w ff16 80
w ff17 f8
w ff18 73
w ff19 06
c ch2 0673f88000
c ch1 05c1f3bf7a
test ch3_fields
w ff1a 00
w ff1b 3c
w ff1c 60
w ff1d d6
w ff1e 03
c ch3 03d6603c00
test unmapped_writes
f ff15
f ff1f
f ff20
f ff21
f ff22
f ff23
c ch1 05c1f3bf7a
c ch2 0673f88000
c ch3 03d6603c00
c control 0
c wave 0123456789abcdeffedcba9876543210
test trigger_rule
w ff14 87
c trig 4
c ch1 87c1f3bf7a
i 3
c trig 4
f ff22
c trig 0
w ff19 c6
c trig 2
w ff18 11
c trig 0
w ff1e 80
c trig 1
w ff1e 07
c trig 0
c ch2 c611f88000
c ch3 07d6603c00
test wave_write
w ff30 9a
w ff3f 5e
w ff37 c4
c wave 9a23456789abcdc4fedcba987654325e
test wave_lock
w ff1a 80
w ff31 00
w ff3f 11
c wave 9a23456789abcdc4fedcba987654325e
c ch3 07d6603c80
w ff1a 00
w ff31 b7
c wave 9ab7456789abcdc4fedcba987654325e
test control_regs
w ff24 77
w ff25 f3
w ff26 8f
c control 8ff377
f ff27
c control 8ff377
test back_to_back
w ff10 11
w ff1b 22
w ff25 5a
w ff3e 6d
w ff16 44
c ch1 87c1f3bf11
c ch3 07d6602200
c control 8f5a77
c wave 9ab7456789abcdc4fedcba9876546d5e
c ch2 c611f84400
c trig 0

/* project.f */
hw/sound_reg_pkg.sv
hw/channel_reg_bank.sv
hw/wave_ram.sv
hw/sound_control_regs.sv
hw/sound_registers.sv
test/sound_registers_tb.sv

/* Makefile */
TOOL       = verilator
FLAGS      = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing --assert
TOP        = sound_registers_tb
RTL_TOP    = sound_registers
FILE_LIST  = project.f
BUILD_DIR  = obj_dir
PASS_TEXT  = PASS: all tests

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILE_LIST)

clean:
	rm -rf $(BUILD_DIR)

/* test/sound_registers_tb.sv */
module sound_registers_tb;

   localparam int    clock_period = 40;
   localparam string test_file    = "test/sound_registers_tests.txt";

   logic                         cpu_clock;
   logic                         reset;
   sound_reg_pkg::reg_write_t    cpu_write;
   sound_reg_pkg::ch1_regs_t     ch1_regs;
   sound_reg_pkg::ch2_regs_t     ch2_regs;
   sound_reg_pkg::ch3_regs_t     ch3_regs;
   logic                         ch1_trigger;
   logic                         ch2_trigger;
   logic                         ch3_trigger;
   sound_reg_pkg::wave_samples_t wave_samples;
   sound_reg_pkg::control_regs_t control;

   string test_name;        // empty until the first name line
   int    test_errors;      // failures in the running test
   int    pass_count;
   int    fail_count;
   int    setup_errors;     // file trouble outside any test
   int    line_count;
   int    watchdog_cycles;  // zero until the file is counted

   sound_registers i_sound_registers (
      .cpu_clock    (cpu_clock),
      .reset        (reset),
      .cpu_write    (cpu_write),
      .ch1_regs     (ch1_regs),
      .ch2_regs     (ch2_regs),
      .ch3_regs     (ch3_regs),
      .ch1_trigger  (ch1_trigger),
      .ch2_trigger  (ch2_trigger),
      .ch3_trigger  (ch3_trigger),
      .wave_samples (wave_samples),
      .control      (control)
   );

   initial begin
      cpu_clock = 1'b0;
      forever #(clock_period / 2) cpu_clock = ~cpu_clock; // 40 units per cycle
   end

   // one strobe, held until the next falling edge
   task automatic drive_write(input logic [15:0] addr, input logic [7:0] data);
      @(negedge cpu_clock);
      cpu_write.addr   = addr;
      cpu_write.data   = data;
      cpu_write.enable = 1'b1;
   endtask

   task automatic idle_cycles(input int count);
      repeat (count) begin
         @(negedge cpu_clock);
         cpu_write.enable = 1'b0; // bus quiet
      end
   endtask

   task automatic report_problem(input string message);
      $display("error: %s", message);
      if (test_name.len() > 0) begin
         test_errors++;
      end else begin
         setup_errors++; // before the first test
      end
   endtask

   task automatic check_output(input string signal, input logic [127:0] expected);
      logic [127:0] actual;
      logic         known;
      @(negedge cpu_clock);
      cpu_write.enable = 1'b0; // last write landed on the rising edge
      known  = 1'b1;
      actual = '0;
      case (signal)
         "ch1":     actual = {88'd0, ch1_regs};
         "ch2":     actual = {88'd0, ch2_regs};
         "ch3":     actual = {88'd0, ch3_regs};
         "trig":    actual = {125'd0, ch1_trigger, ch2_trigger, ch3_trigger};
         "wave":    actual = wave_samples;
         "control": actual = {104'd0, control};
         default:   known  = 1'b0;
      endcase
      if (!known) begin
         report_problem($sformatf("unknown output name %s in test %s", signal, test_name));
      end else begin
         assert (actual == expected) else begin
            $display("Mismatch in test %s: %s expected %0h, actual %0h",
                     test_name, signal, expected, actual);
            test_errors++;
         end
      end
   endtask

   // result line of the test in progress
   task automatic close_test();
      if (test_name.len() > 0) begin
         if (test_errors == 0) begin
            $display("test %s: ok", test_name);
            pass_count++;
         end else begin
            $display("test %s: %0d errors", test_name, test_errors);
            fail_count++;
         end
      end
      test_errors = 0;
   endtask

   task automatic run_line(input string line);
      string        kind;
      string        word;
      logic [127:0] value;
      logic [15:0]  addr;
      logic [7:0]   data;
      int           count;
      if ($sscanf(line, "%s", kind) != 1) begin
         return; // blank line
      end
      if (kind.getc(0) == 8'h23) begin
         return; // comment
      end
      case (kind)
         "test": begin
            if ($sscanf(line, "%s %s", kind, word) == 2) begin
               close_test();
               test_name = word;
            end else begin
               report_problem("name line without a test name");
            end
         end
         "w": begin
            if ($sscanf(line, "%s %h %h", kind, addr, data) == 3) begin
               drive_write(addr, data);
            end else begin
               report_problem("write line needs an address and a data byte");
            end
         end
         "f": begin
            if ($sscanf(line, "%s %h", kind, addr) == 2) begin
               drive_write(addr, 8'($urandom())); // random filler byte
            end else begin
               report_problem("filler line needs an address");
            end
         end
         "i": begin
            if ($sscanf(line, "%s %d", kind, count) == 2) begin
               idle_cycles(count);
            end else begin
               report_problem("idle line needs a cycle count");
            end
         end
         "c": begin
            if ($sscanf(line, "%s %s %h", kind, word, value) == 3) begin
               check_output(word, value);
            end else begin
               report_problem("check line needs an output name and a value");
            end
         end
         default: report_problem($sformatf("unrecognized line kind %s", kind));
      endcase
   endtask

   initial begin
      int    fd;
      string line;
      reset           = 1'b1;
      cpu_write       = '0;
      test_name       = "";
      test_errors     = 0;
      pass_count      = 0;
      fail_count      = 0;
      setup_errors    = 0;
      line_count      = 0;
      watchdog_cycles = 0;
      void'($urandom(32'h0567_ea17));

      fd = $fopen(test_file, "r");
      assert (fd != 0) else begin
         $display("could not open the test file %s", test_file);
         setup_errors++;
      end
      if (fd != 0) begin
         while ($fgets(line, fd) != 0) begin
            line_count++;
         end
         $fclose(fd);
      end
      watchdog_cycles = line_count * 4 + 100; // worst line is four cycles

      repeat (5) @(posedge cpu_clock);
      @(negedge cpu_clock);
      reset = 1'b0;

      if (fd != 0) begin
         fd = $fopen(test_file, "r");
         while ($fgets(line, fd) != 0) begin
            run_line(line);
         end
         $fclose(fd);
      end
      close_test();
      if (pass_count + fail_count == 0) begin
         report_problem("the test file holds no tests");
      end

      $display("tests passed %0d, failed %0d", pass_count, fail_count);
      if (fail_count == 0 && setup_errors == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

   initial begin
      wait (watchdog_cycles > 0);
      #(watchdog_cycles * clock_period);
      $display("timeout: tests still running after %0d cycles", watchdog_cycles);
      $display("FAIL: see errors above");
      $finish;
   end

endmodule

/* hw/sound_registers.sv */
module sound_registers (
   input  logic                         cpu_clock,
   input  logic                         reset,
   input  sound_reg_pkg::reg_write_t    cpu_write,
   output sound_reg_pkg::ch1_regs_t     ch1_regs,
   output sound_reg_pkg::ch2_regs_t     ch2_regs,
   output sound_reg_pkg::ch3_regs_t     ch3_regs,
   output logic                         ch1_trigger,
   output logic                         ch2_trigger,
   output logic                         ch3_trigger,
   output sound_reg_pkg::wave_samples_t wave_samples,
   output sound_reg_pkg::control_regs_t control
);

   logic wave_lock; // channel 3 playing, wave ram is read only

   // tone with sweep, FF10..FF14
   channel_reg_bank #(
      .payload_t    (sound_reg_pkg::ch1_regs_t),
      .base_address (sound_reg_pkg::ch1_base)
   ) i_ch1_bank (
      .cpu_clock (cpu_clock),
      .reset     (reset),
      .cpu_write (cpu_write),
      .regs      (ch1_regs),
      .trigger   (ch1_trigger)
   );

   // tone, FF16..FF19 behind the FF15 pad
   channel_reg_bank #(
      .payload_t    (sound_reg_pkg::ch2_regs_t),
      .base_address (sound_reg_pkg::ch2_base)
   ) i_ch2_bank (
      .cpu_clock (cpu_clock),
      .reset     (reset),
      .cpu_write (cpu_write),
      .regs      (ch2_regs),
      .trigger   (ch2_trigger)
   );

   // wave channel, FF1A..FF1E
   channel_reg_bank #(
      .payload_t    (sound_reg_pkg::ch3_regs_t),
      .base_address (sound_reg_pkg::ch3_base)
   ) i_ch3_bank (
      .cpu_clock (cpu_clock),
      .reset     (reset),
      .cpu_write (cpu_write),
      .regs      (ch3_regs),
      .trigger   (ch3_trigger)
   );

   // NR30 bit 7
   assign wave_lock = ch3_regs.on_off.enable;

   wave_ram i_wave_ram (
      .cpu_clock (cpu_clock),
      .reset     (reset),
      .cpu_write (cpu_write),
      .wave_lock (wave_lock),
      .samples   (wave_samples)
   );

   // master volume, routing, master enable
   sound_control_regs i_control_regs (
      .cpu_clock (cpu_clock),
      .reset     (reset),
      .cpu_write (cpu_write),
      .control   (control)
   );

endmodule

/* hw/sound_control_regs.sv */
module sound_control_regs (
   input  logic                         cpu_clock,
   input  logic                         reset,
   input  sound_reg_pkg::reg_write_t    cpu_write,
   output sound_reg_pkg::control_regs_t control
);

   // NR50 in byte 0, NR52 in byte 2
   logic [sound_reg_pkg::control_bytes-1:0][7:0] control_q;

   logic [15:0] offset;                                        // distance from FF24
   logic [$clog2(sound_reg_pkg::control_bytes)-1:0] index;    // byte select
   logic        hit;

   assign offset = cpu_write.addr - sound_reg_pkg::control_base;
   assign index  = offset[$clog2(sound_reg_pkg::control_bytes)-1:0];
   assign hit    = cpu_write.enable && (offset < 16'(sound_reg_pkg::control_bytes));

   always_ff @(posedge cpu_clock or posedge reset) begin
      if (reset) begin
         control_q <= '0; // master off, no routing, volume 0
      end else if (hit) begin
         // NR52 flag bits are kept as written
         control_q[index] <= cpu_write.data;
      end
   end

   assign control = sound_reg_pkg::control_regs_t'(control_q);

endmodule

/* hw/wave_ram.sv */
module wave_ram (
   input  logic                         cpu_clock,
   input  logic                         reset,
   input  sound_reg_pkg::reg_write_t    cpu_write,
   input  logic                         wave_lock,
   output sound_reg_pkg::wave_samples_t samples
);

   // 16 bytes, FF30 in the top slot so sample zero leads
   logic [sound_reg_pkg::wave_bytes-1:0][7:0] ram_q;

   logic [15:0] offset;                                  // distance from FF30
   logic [$clog2(sound_reg_pkg::wave_bytes)-1:0] index; // byte number from FF30
   logic [$clog2(sound_reg_pkg::wave_bytes)-1:0] slot;  // position in ram_q
   logic        in_range;
   logic        write_ok;

   assign offset   = cpu_write.addr - sound_reg_pkg::wave_base;
   assign index    = offset[$clog2(sound_reg_pkg::wave_bytes)-1:0];
   assign in_range = offset < 16'(sound_reg_pkg::wave_bytes);

   // reversed order, byte 0 goes to slot 15
   assign slot = ~index;

   // cpu loses access while channel 3 plays back
   assign write_ok = cpu_write.enable && in_range && !wave_lock;

   always_ff @(posedge cpu_clock or posedge reset) begin
      if (reset) begin
         ram_q <= sound_reg_pkg::wave_reset_pattern; // arbitrary ramp up and down
      end else if (write_ok) begin
         ram_q[slot] <= cpu_write.data; // two samples per byte, high nibble first
      end
   end

   assign samples = ram_q;

endmodule

/* hw/channel_reg_bank.sv */
module channel_reg_bank #(
   parameter type         payload_t    = sound_reg_pkg::ch1_regs_t,
   parameter logic [15:0] base_address = sound_reg_pkg::ch1_base
) (
   input  logic                      cpu_clock,
   input  logic                      reset,
   input  sound_reg_pkg::reg_write_t cpu_write,
   output payload_t                  regs,
   output logic                      trigger
);

   logic [sound_reg_pkg::bank_bytes-1:0][7:0] bank_q; // byte i at base + i

   logic [15:0] offset;                                     // distance from base
   logic [$clog2(sound_reg_pkg::bank_bytes)-1:0] index;    // byte select
   logic        in_range;                                   // address inside the bank
   logic        is_pad;                                     // unmapped slot
   logic        hit;                                        // write lands here
   logic        trigger_hit;                                // write to frequency high

   assign offset   = cpu_write.addr - base_address; // wraps high below base
   assign index    = offset[$clog2(sound_reg_pkg::bank_bytes)-1:0];
   assign in_range = offset < 16'(sound_reg_pkg::bank_bytes);

   // FF15 sits below NR21, the hardware has no register there
   assign is_pad = cpu_write.addr == sound_reg_pkg::ch2_pad_address;

   assign hit         = cpu_write.enable && in_range && !is_pad;
   assign trigger_hit = hit && (offset == 16'(sound_reg_pkg::trigger_offset));

   always_ff @(posedge cpu_clock or posedge reset) begin
      if (reset) begin
         bank_q <= '0; // channel starts silent
      end else if (hit) begin
         bank_q[index] <= cpu_write.data; // whole byte, unused bits too
      end
   end

   // restart level, valid until the next cpu write of any kind
   always_ff @(posedge cpu_clock or posedge reset) begin
      if (reset) begin
         trigger <= 1'b0;
      end else if (cpu_write.enable) begin
         trigger <= trigger_hit && cpu_write.data[7]; // initial bit
      end
   end

   assign regs = payload_t'(bank_q); // byte 0 is the low byte of the struct

endmodule

/* hw/sound_reg_pkg.sv */
package sound_reg_pkg;

   // cpu side register map
   localparam logic [15:0] ch1_base     = 16'hFF10; // NR10..NR14, tone with sweep
   localparam logic [15:0] ch2_base     = 16'hFF15; // pad slot, then NR21..NR24
   localparam logic [15:0] ch3_base     = 16'hFF1A; // NR30..NR34, wave channel
   localparam logic [15:0] control_base = 16'hFF24; // NR50..NR52
   localparam logic [15:0] wave_base    = 16'hFF30; // wave pattern ram, 16 bytes

   localparam logic [15:0] ch2_pad_address = ch2_base; // no register behind this one

   localparam int bank_bytes     = 5;  // registers per channel
   localparam int trigger_offset = 4;  // frequency high register in each bank
   localparam int wave_bytes     = 16; // 32 four bit samples
   localparam int control_bytes  = 3;  // volume, routing, on/off

   // power up waveform, first byte sits at FF30
   localparam logic [127:0] wave_reset_pattern =
      128'h0123_4567_89AB_CDEF_FEDC_BA98_7654_3210;

   // one cpu write strobe
   typedef struct packed {
      logic [15:0] addr;   // cpu address
      logic [7:0]  data;   // write byte
      logic        enable; // strobe, one cycle per write
   } reg_write_t;

   typedef struct packed {
      logic       unused;         // bit 7 not used
      logic [2:0] sweep_time;     // 0 = sweep off, n/128 Hz steps
      logic       decreasing;     // 1 = frequency goes down
      logic [2:0] shift_count;    // X(t) +/- X(t-1)/2^n
   } sweep_t;

   typedef struct packed {
      logic [1:0] duty;           // 12.5, 25, 50, 75 percent
      logic [5:0] length;         // (64 - t1) / 256 s
   } duty_length_t;

   typedef struct packed {
      logic [3:0] initial_volume; // 0 = silent
      logic       increasing;     // envelope direction
      logic [2:0] sweep_count;    // step length n/64 s, 0 stops envelope
   } envelope_t;

   typedef struct packed {
      logic       restart;        // initial bit, also raises the trigger
      logic       dont_loop;      // stop when length expires
      logic [2:0] unused;
      logic [2:0] freq_high;      // upper 3 bits of 11 bit frequency
      logic [7:0] freq_low;       // lower 8 bits
   } freq_ctrl_t;

   // channel 1, byte 0 (FF10) at the bottom
   typedef struct packed {
      freq_ctrl_t   freq_ctrl;    // FF13, FF14
      envelope_t    envelope;     // FF12
      duty_length_t duty_length;  // FF11
      sweep_t       sweep;        // FF10
   } ch1_regs_t;

   // channel 2 has no sweep register
   typedef struct packed {
      freq_ctrl_t   freq_ctrl;    // FF18, FF19
      envelope_t    envelope;     // FF17
      duty_length_t duty_length;  // FF16
      logic [7:0]   pad;          // FF15, never written
   } ch2_regs_t;

   typedef struct packed {
      logic       unused_hi;
      logic [1:0] level;          // mute, 100, 50, 25 percent
      logic [4:0] unused_lo;
   } ch3_level_t;

   typedef struct packed {
      logic       enable;         // playback on, locks the wave ram
      logic [6:0] unused;
   } ch3_on_off_t;

   typedef struct packed {
      freq_ctrl_t  freq_ctrl;     // FF1D, FF1E
      ch3_level_t  output_level;  // FF1C
      logic [7:0]  length;        // FF1B, (256 - t1) / 256 s
      ch3_on_off_t on_off;        // FF1A
   } ch3_regs_t;

   typedef struct packed {
      logic       master_enable;  // all sound circuits on
      logic [2:0] unused;
      logic       ch4_on;         // status flags, stored as written
      logic       ch3_on;
      logic       ch2_on;
      logic       ch1_on;
   } on_off_t;

   typedef struct packed {
      logic [3:0] so2_channels;   // channels 4..1 to terminal so2
      logic [3:0] so1_channels;   // channels 4..1 to terminal so1
   } routing_t;

   typedef struct packed {
      logic       so2_vin;        // cartridge vin to so2
      logic [2:0] so2_level;      // master volume so2
      logic       so1_vin;
      logic [2:0] so1_level;
   } volume_t;

   typedef struct packed {
      on_off_t  on_off;           // FF26
      routing_t routing;          // FF25
      volume_t  volume;           // FF24
   } control_regs_t;

   typedef logic [127:0] wave_samples_t; // sample zero in the top nibble

endpackage
